//--- compile.f
hdl/colmix_pkg.sv
hdl/layer_prio.sv
hdl/palette_ram.sv
hdl/video_out.sv
hdl/colmix_top.sv
bench/colmix_assertions.sv
bench/colmix_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module colmix_tb \
		-f compile.f -o Vcolmix_tb
	./obj_dir/Vcolmix_tb +verilator+error+limit+100000 | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/colmix_tb.sv
`timescale 1ns/10ps

module colmix_tb;

    localparam int LAT = colmix_pkg::PIXEL_LATENCY;
    // two cpu writes per palette entry, one per RAM
    localparam int PAL_WRITES = 2 * 2**colmix_pkg::PAL_AW;
    localparam int PIXEL_COUNT = 600;
    localparam int WATCHDOG_NS = (PAL_WRITES + PIXEL_COUNT + 64) * 2 * 4;

    logic clk = 1'b0;
    logic rst_n;
    logic pxl_cen = 1'b0;
    logic cpu_cen;
    colmix_pkg::layer_pixels_t pxl;
    colmix_pkg::layer_en_t gfx_en;
    logic lhbl;
    logic lvbl;
    colmix_pkg::cpu_bus_t cpu;
    colmix_pkg::rgb_t rgb;
    logic lhbl_dly;
    logic lvbl_dly;
    logic run_pixels = 1'b0;
    int tests_passed = 0;
    int tests_failed = 0;

    colmix_top i_dut (.*);

    always #2 clk = ~clk;

    // pixel strobe on every other cycle once video runs
    always @(posedge clk) begin
        #1;
        pxl_cen = run_pixels && !pxl_cen;
    end

    // kind 0..3 aims at one priority case, anything else stays random
    function automatic colmix_pkg::layer_pixels_t random_pixel(input int kind);
        colmix_pkg::layer_pixels_t p;
        p = 28'($urandom);
        case (kind)
            0: p.char_pxl[1:0] = 2'($urandom_range(0, 2));
            1: begin
                p.char_pxl[1:0] = 2'b11;
                p.obj_pxl[3:0] = 4'($urandom_range(0, 14));
                p.scr_pxl[7] = 1'b0;
            end
            2: begin
                p.char_pxl[1:0] = 2'b11;
                p.obj_pxl[3:0] = 4'($urandom_range(0, 14));
                p.scr_pxl[7] = 1'b1;
                p.scr_pxl[3:0] = 4'($urandom_range(7, 11));
            end
            3: begin
                p.char_pxl[1:0] = 2'b11;
                p.obj_pxl[3:0] = 4'hf;
                p.scr_pxl[3:0] = 4'h0;
            end
            default: ;
        endcase
        return p;
    endfunction

    // wait for a strobe edge, then present the next pixel
    task automatic send_pixel(input colmix_pkg::layer_pixels_t p,
                              input colmix_pkg::layer_en_t en, input logic hbl, input logic vbl);
        do @(posedge clk); while (!pxl_cen);
        #1;
        pxl = p;
        gfx_en = en;
        lhbl = hbl;
        lvbl = vbl;
    endtask

    task automatic wait_strobes(input int n);
        repeat (n) begin
            do @(posedge clk); while (!pxl_cen);
        end
    endtask

    // one write per cycle, cpu_cen is always high
    task automatic write_word(input logic [9:0] addr, input logic [7:0] data,
                              input logic rg_cs, input logic b_cs);
        @(posedge clk);
        #1;
        cpu.addr = addr;
        cpu.data = data;
        cpu.wr_n = 1'b0;
        cpu.rg_cs = rg_cs;
        cpu.b_cs = b_cs;
    endtask

    task automatic cpu_idle();
        @(posedge clk);
        #1;
        cpu.wr_n = 1'b1;
        cpu.rg_cs = 1'b0;
        cpu.b_cs = 1'b0;
    endtask

    task automatic report_test(input string name, input int base);
        int errs;
        errs = i_dut.u_chk.fail_count - base;
        if (errs == 0) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail, %0d assertion failures", name, errs);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

    initial begin
        int base;
        void'($urandom(92930));
        rst_n = 1'b0;
        cpu_cen = 1'b0;
        pxl = '0;
        gfx_en = '1;
        lhbl = 1'b1;
        lvbl = 1'b1;
        cpu = '0;
        cpu.wr_n = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        cpu_cen = 1'b1;

        // outputs stay blanked while the palette fills
        base = i_dut.u_chk.fail_count;
        for (int a = 0; a < 2**colmix_pkg::PAL_AW; a++) begin
            write_word(10'(a), 8'(a), 1'b1, 1'b0);
            write_word(10'(a), {2'(a >> 8), 2'(a), 4'h0}, 1'b0, 1'b1);
        end
        cpu_idle();
        report_test("reset and palette load", base);
        run_pixels = 1'b1;

        base = i_dut.u_chk.fail_count;
        repeat (300) send_pixel(random_pixel($urandom_range(0, 4)), '1, 1'b1, 1'b1);
        wait_strobes(LAT + 1);
        report_test("priority and address", base);

        base = i_dut.u_chk.fail_count;
        repeat (100) begin
            send_pixel(random_pixel($urandom_range(0, 4)), 2'($urandom_range(0, 2)),
                       1'b1, 1'b1);
        end
        wait_strobes(LAT + 1);
        report_test("layer enables", base);

        base = i_dut.u_chk.fail_count;
        repeat (100) begin
            send_pixel(random_pixel(4), '1, $urandom_range(0, 3) != 0,
                       $urandom_range(0, 3) != 0);
        end
        send_pixel(random_pixel(4), '1, 1'b1, 1'b1);
        wait_strobes(LAT + 1);
        report_test("blanking", base);

        // char code 000100 maps to palette entry 0x304
        base = i_dut.u_chk.fail_count;
        write_word(10'h304, 8'ha5, 1'b1, 1'b0);
        write_word(10'h304, 8'h70, 1'b0, 1'b1);
        write_word(10'h304, 8'h00, 1'b0, 1'b0);
        cpu_idle();
        repeat (8) send_pixel({6'b000100, 8'h00, 7'h00, 7'h00}, '1, 1'b1, 1'b1);
        wait_strobes(LAT + 1);
        report_test("palette update", base);

        $display("tests: %0d passed, %0d failed", tests_passed, tests_failed);
        if (tests_failed == 0 && i_dut.u_chk.fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- bench/colmix_assertions.sv
`timescale 1ns/10ps

module colmix_assertions (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      pxl_cen,
    input logic                      cpu_cen,
    input colmix_pkg::layer_pixels_t pxl,
    input colmix_pkg::layer_en_t     gfx_en,
    input logic                      lhbl,
    input logic                      lvbl,
    input colmix_pkg::cpu_bus_t      cpu,
    input colmix_pkg::rgb_t          rgb,
    input logic                      lhbl_dly,
    input logic                      lvbl_dly
);

    localparam int LAT = colmix_pkg::PIXEL_LATENCY;

    // expected palette, red/green byte on top of the blue nibble
    logic [11:0] pal_model [2**colmix_pkg::PAL_AW];
    // palette address of the pixels in stages 1 to 3
    logic [colmix_pkg::PAL_AW-1:0] addr_pipe [3];
    logic [LAT-1:0] hbl_pipe;
    logic [LAT-1:0] vbl_pipe;
    logic [LAT-1:0] blank_pipe;
    logic [11:0] exp_q;
    colmix_pkg::rgb_t exp_rgb;
    int strobes;
    int fail_count = 0;

    // winning layer and its palette address, straight from the priority table
    function automatic logic [colmix_pkg::PAL_AW-1:0] expected_addr(
        input colmix_pkg::layer_pixels_t p,
        input colmix_pkg::layer_en_t en
    );
        logic char_on;
        logic obj_on;
        logic scr_front;
        char_on = en.char_en && (p.char_pxl[1:0] != 2'b11);
        obj_on = en.obj_en && (p.obj_pxl[3:0] != 4'hf);
        scr_front = p.scr_pxl[7] && (p.scr_pxl[3:0] inside {[4'd7:4'd11]});
        if (char_on) begin
            return {colmix_pkg::SEL_CHAR, 2'b00, p.char_pxl[5:2], p.char_pxl[0],
                    p.char_pxl[1]};
        end
        if (obj_on && !scr_front) begin
            return {colmix_pkg::SEL_OBJ, 1'b1, p.obj_pxl};
        end
        // scroll 1 in front of an object, or no code 0
        if (obj_on || p.scr_pxl[3:0] != 4'h0) begin
            return {colmix_pkg::SEL_SCR1, 1'b0, p.scr_pxl[6:0]};
        end
        return {colmix_pkg::SEL_SCR2, 1'b0, p.scr2_pxl[6:4], p.scr2_pxl[0],
                p.scr2_pxl[1], p.scr2_pxl[2], p.scr2_pxl[3]};
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // load pattern: rg is the low address byte, blue is a[9:8] then a[1:0]
            for (int a = 0; a < 2**colmix_pkg::PAL_AW; a++) begin
                pal_model[a] <= {8'(a), 2'(a >> 8), 2'(a)};
            end
            hbl_pipe <= '0;
            vbl_pipe <= '0;
            blank_pipe <= '0;
            exp_rgb <= '0;
            strobes <= 0;
        end else begin
            if (cpu_cen && !cpu.wr_n && cpu.rg_cs) begin
                pal_model[cpu.addr][11:4] <= cpu.data;
            end
            if (cpu_cen && !cpu.wr_n && cpu.b_cs) begin
                pal_model[cpu.addr][3:0] <= cpu.data[7:4];
            end
            if (pxl_cen) begin
                addr_pipe[0] <= expected_addr(pxl, gfx_en);
                addr_pipe[1] <= addr_pipe[0];
                addr_pipe[2] <= addr_pipe[1];
                // palette read at stage 4 sees the word before this edge's write
                exp_q <= pal_model[addr_pipe[2]];
                hbl_pipe <= {hbl_pipe[LAT-2:0], lhbl};
                vbl_pipe <= {vbl_pipe[LAT-2:0], lvbl};
                blank_pipe <= {blank_pipe[LAT-2:0], ~(lhbl & lvbl)};
                exp_rgb <= blank_pipe[LAT-2] ? 12'h000 : exp_q;
                if (strobes < LAT) begin
                    strobes <= strobes + 1;
                end
            end
        end
    end

    // outputs hold their reset values until pixels start moving
    idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        (strobes == 0) |-> (rgb == '0 && !lhbl_dly && !lvbl_dly))
    else begin
        fail_count++;
        $error("outputs left the reset state before the first pixel strobe");
    end

    color_matches: assert property (@(posedge clk) disable iff (!rst_n)
        (strobes >= LAT) |-> (rgb == exp_rgb))
    else begin
        fail_count++;
        $error("mismatch at %0t: rgb %h, expected %h", $time, rgb, exp_rgb);
    end

    blank_delay: assert property (@(posedge clk) disable iff (!rst_n)
        (lhbl_dly == hbl_pipe[LAT-1]) && (lvbl_dly == vbl_pipe[LAT-1]))
    else begin
        fail_count++;
        $error("mismatch at %0t: blanking %b%b, expected %b%b", $time, lhbl_dly,
               lvbl_dly, hbl_pipe[LAT-1], vbl_pipe[LAT-1]);
    end

    black_when_blanked: assert property (@(posedge clk) disable iff (!rst_n)
        (!lhbl_dly || !lvbl_dly) |-> (rgb == '0))
    else begin
        fail_count++;
        $error("rgb is not black while blanking is active");
    end

endmodule

bind colmix_top colmix_assertions u_chk (.*);

//--- hdl/colmix_top.sv
`timescale 1ns/10ps

module colmix_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      pxl_cen,
    input  logic                      cpu_cen,
    // layer pixels and debug enables
    input  colmix_pkg::layer_pixels_t pxl,
    input  colmix_pkg::layer_en_t     gfx_en,
    // active low blanking
    input  logic                      lhbl,
    input  logic                      lvbl,
    // palette write port
    input  colmix_pkg::cpu_bus_t      cpu,
    output colmix_pkg::rgb_t          rgb,
    output logic                      lhbl_dly,
    output logic                      lvbl_dly
);

    logic [colmix_pkg::PAL_AW-1:0] pal_addr;
    logic [colmix_pkg::PAL_RG_DW-1:0] pal_rg;
    logic [colmix_pkg::PAL_B_DW-1:0] pal_b;
    logic we_rg;
    logic we_b;

    // each RAM only sees its own chip select
    assign we_rg = cpu.rg_cs & ~cpu.wr_n;
    assign we_b = cpu.b_cs & ~cpu.wr_n;

    // stages 1 to 3
    layer_prio u_prio (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .pxl      (pxl),
        .gfx_en   (gfx_en),
        .pal_addr (pal_addr)
    );

    // stage 4, red and green
    palette_ram #(.DW(colmix_pkg::PAL_RG_DW)) u_pal_rg (
        .clk     (clk),
        .cpu_cen (cpu_cen),
        .we      (we_rg),
        .wr_addr (cpu.addr),
        .wr_data (cpu.data),
        .pxl_cen (pxl_cen),
        .rd_addr (pal_addr),
        .q       (pal_rg)
    );

    // stage 4, blue comes from the upper data nibble
    palette_ram #(.DW(colmix_pkg::PAL_B_DW)) u_pal_b (
        .clk     (clk),
        .cpu_cen (cpu_cen),
        .we      (we_b),
        .wr_addr (cpu.addr),
        .wr_data (cpu.data[7:4]),
        .pxl_cen (pxl_cen),
        .rd_addr (pal_addr),
        .q       (pal_b)
    );

    // stage 5
    video_out u_out (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .rg       (pal_rg),
        .b        (pal_b),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .rgb      (rgb),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly)
    );

endmodule

//--- hdl/video_out.sv
`timescale 1ns/10ps

module video_out (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             pxl_cen,
    // palette words from the two RAMs
    input  logic [colmix_pkg::PAL_RG_DW-1:0] rg,
    input  logic [colmix_pkg::PAL_B_DW-1:0]  b,
    // active low blanking, aligned with the layer pixels
    input  logic                             lhbl,
    input  logic                             lvbl,
    output colmix_pkg::rgb_t                 rgb,
    output logic                             lhbl_dly,
    output logic                             lvbl_dly
);

    // blanking delay lines, entry k holds the level of pipeline stage k+1
    logic [colmix_pkg::PIXEL_LATENCY-1:0] hbl_line;
    logic [colmix_pkg::PIXEL_LATENCY-1:0] vbl_line;

    colmix_pkg::rgb_t pal_rgb;
    logic pal_blank;

    // red in the upper nibble, green in the lower
    assign pal_rgb.red = rg[7:4];
    assign pal_rgb.green = rg[3:0];
    assign pal_rgb.blue = b;

    // blanking of the pixel whose palette word is on rg/b now
    assign pal_blank = ~hbl_line[colmix_pkg::PIXEL_LATENCY-2] |
                       ~vbl_line[colmix_pkg::PIXEL_LATENCY-2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // reset shows as blanked video
            hbl_line <= '0;
            vbl_line <= '0;
            rgb <= '0;
        end else if (pxl_cen) begin
            hbl_line <= {hbl_line[colmix_pkg::PIXEL_LATENCY-2:0], lhbl};
            vbl_line <= {vbl_line[colmix_pkg::PIXEL_LATENCY-2:0], lvbl};
            // black outside the visible area
            if (pal_blank) begin
                rgb <= '0;
            end else begin
                rgb <= pal_rgb;
            end
        end
    end

    // last tap lines up with the registered rgb
    assign lhbl_dly = hbl_line[colmix_pkg::PIXEL_LATENCY-1];
    assign lvbl_dly = vbl_line[colmix_pkg::PIXEL_LATENCY-1];

endmodule

//--- hdl/palette_ram.sv
`timescale 1ns/10ps

module palette_ram #(
    parameter int DW = 8
) (
    input  logic                          clk,
    // write side, cpu clock enable
    input  logic                          cpu_cen,
    input  logic                          we,
    input  logic [colmix_pkg::PAL_AW-1:0] wr_addr,
    input  logic [DW-1:0]                 wr_data,
    // read side, pixel clock enable
    input  logic                          pxl_cen,
    input  logic [colmix_pkg::PAL_AW-1:0] rd_addr,
    output logic [DW-1:0]                 q
);

    // one entry per palette address
    logic [DW-1:0] mem [2**colmix_pkg::PAL_AW];

    // cpu writes may land at any time, also during active video
    always_ff @(posedge clk) begin
        if (cpu_cen && we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, stage 4 of the pixel pipeline
    // same-cycle write to the read address returns the old word
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            q <= mem[rd_addr];
        end
    end

endmodule

//--- hdl/layer_prio.sv
`timescale 1ns/10ps

module layer_prio (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pxl_cen,
    input  colmix_pkg::layer_pixels_t     pxl,
    input  colmix_pkg::layer_en_t         gfx_en,
    output logic [colmix_pkg::PAL_AW-1:0] pal_addr
);

    // stage 1 capture
    colmix_pkg::layer_pixels_t s1_pxl;
    colmix_pkg::layer_en_t s1_en;
    // stage 2 select, with the pixel it was decided on
    colmix_pkg::layer_pixels_t s2_pxl;
    colmix_pkg::layer_sel_t s2_sel;
    colmix_pkg::layer_sel_t next_sel;

    logic char_blank;
    logic obj_blank;
    logic scr_over_obj;

    // transparency codes, a disabled layer counts as transparent
    assign char_blank = (&s1_pxl.char_pxl[1:0]) | ~s1_en.char_en;
    assign obj_blank = (&s1_pxl.obj_pxl[3:0]) | ~s1_en.obj_en;

    // scroll 1 with its priority bit set covers objects
    // only for color codes 7 to 11, which are never the blank code
    assign scr_over_obj = s1_pxl.scr_pxl[7] &&
                          (s1_pxl.scr_pxl[3:0] >= 4'd7) &&
                          (s1_pxl.scr_pxl[3:0] <= 4'd11);

    // fixed priority, replaces the priority PROM
    always_comb begin
        if (!char_blank) begin
            next_sel = colmix_pkg::SEL_CHAR;
        end else if (!obj_blank) begin
            next_sel = scr_over_obj ? colmix_pkg::SEL_SCR1 : colmix_pkg::SEL_OBJ;
        end else if (s1_pxl.scr_pxl[3:0] == 4'd0) begin
            // scroll 1 code 0 lets scroll 2 through
            next_sel = colmix_pkg::SEL_SCR2;
        end else begin
            next_sel = colmix_pkg::SEL_SCR1;
        end
    end

    // palette address for the chosen layer
    function automatic logic [colmix_pkg::PAL_AW-1:0] build_addr(
        input colmix_pkg::layer_sel_t sel,
        input colmix_pkg::layer_pixels_t p
    );
        logic [colmix_pkg::PAL_AW-3:0] color;
        color = '0;
        case (sel)
            colmix_pkg::SEL_CHAR: begin
                // char bits 0 and 1 swap places
                color = {2'b00, p.char_pxl[5:2], p.char_pxl[0], p.char_pxl[1]};
            end
            colmix_pkg::SEL_SCR1: begin
                color = {1'b0, p.scr_pxl[6:0]};
            end
            colmix_pkg::SEL_OBJ: begin
                color = {1'b1, p.obj_pxl};
            end
            colmix_pkg::SEL_SCR2: begin
                // scroll 2 low nibble is bit reversed
                color = {1'b0, p.scr2_pxl[6:4], p.scr2_pxl[0], p.scr2_pxl[1],
                         p.scr2_pxl[2], p.scr2_pxl[3]};
            end
        endcase
        return {sel, color};
    endfunction

    // control path, advances only on pixel strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_en <= '0;
            s2_sel <= colmix_pkg::SEL_SCR2;
            pal_addr <= '0;
        end else if (pxl_cen) begin
            s1_en <= gfx_en;
            s2_sel <= next_sel;
            pal_addr <= build_addr(s2_sel, s2_pxl);
        end
    end

    // pixel payload follows the select one stage behind
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            s1_pxl <= pxl;
            s2_pxl <= s1_pxl;
        end
    end

endmodule

//--- hdl/colmix_pkg.sv
package colmix_pkg;

    // palette address: 2 layer-select bits on top of an 8-bit color index
    localparam int PAL_AW = 10;

    // red/green RAM holds two nibbles, blue RAM holds one
    localparam int PAL_RG_DW = 8;
    localparam int PAL_B_DW = 4;

    // pxl_cen strobes from layer input to rgb output
    // capture, select, address, palette read, output register
    localparam int PIXEL_LATENCY = 5;

    // one pixel from each tile/sprite layer
    typedef struct packed {
        // character layer, low two bits are the transparency code
        logic [5:0] char_pxl;
        // scroll 1, bit 7 is its priority bit
        logic [7:0] scr_pxl;
        // scroll 2, always opaque
        logic [6:0] scr2_pxl;
        // object layer, low nibble all ones means transparent
        logic [6:0] obj_pxl;
    } layer_pixels_t;

    // debug enables for the layers that can be switched off
    typedef struct packed {
        logic char_en;
        logic obj_en;
    } layer_en_t;

    // cpu side of the palette, plain strobes and levels only
    typedef struct packed {
        logic [PAL_AW-1:0] addr;
        logic [7:0] data;
        // active low write
        logic wr_n;
        // red/green palette select
        logic rg_cs;
        // blue palette select
        logic b_cs;
    } cpu_bus_t;

    // 4 bits per gun
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    // winning layer, also the top two bits of the palette address
    typedef enum logic [1:0] {
        SEL_SCR2 = 2'b00,
        SEL_SCR1 = 2'b01,
        SEL_OBJ = 2'b10,
        SEL_CHAR = 2'b11
    } layer_sel_t;

endpackage
